// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_fe_top
FLIST     ?= build.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^sim passed$$"

clean:
	rm -rf obj_dir

// File: build.f
design/fe_cfg_pkg.sv
design/fe_types_pkg.sv
design/trap_vector_sel.sv
design/fetch_pc_ctrl.sv
design/fetch_pipe.sv
design/btb.sv
design/fe_top.sv
test/tb_clk_gen.sv
test/fe_top_sva.sv
test/tb_fe_top.sv

// File: design/btb.sv
/* direct mapped, full tag; lookup result is registered and valid one cycle later
   a lookup in the same cycle as an update sees the old entry */
`timescale 1ns/1ps
`default_nettype none

module btb (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  input  logic                        i_lookup_valid,
  input  logic [fe_cfg_pkg::XLEN-1:0] i_lookup_pc,
  input  logic                        i_br_valid,
  input  logic                        i_br_mispredict,
  input  logic                        i_br_taken,
  input  logic [fe_cfg_pkg::XLEN-1:0] i_br_pc,
  input  logic [fe_cfg_pkg::XLEN-1:0] i_br_target,
  output logic                        o_pred_taken,
  output logic [fe_cfg_pkg::XLEN-1:0] o_pred_target
);

  logic [fe_cfg_pkg::BTB_ENTRIES-1:0] r_valid;
  logic [fe_cfg_pkg::BTB_TAG_W-1:0]   r_tag    [fe_cfg_pkg::BTB_ENTRIES];
  logic [fe_cfg_pkg::XLEN-1:0]        r_target [fe_cfg_pkg::BTB_ENTRIES];

  logic [fe_cfg_pkg::BTB_IDX_W-1:0]   w_lk_idx;
  logic [fe_cfg_pkg::BTB_TAG_W-1:0]   w_lk_tag;
  logic [fe_cfg_pkg::BTB_IDX_W-1:0]   w_up_idx;
  logic [fe_cfg_pkg::BTB_TAG_W-1:0]   w_up_tag;
  logic                               w_lk_hit;
  logic                               w_up_write;
  logic                               w_up_inval;

  // index just above the byte offset
  assign w_lk_idx = i_lookup_pc[fe_cfg_pkg::OFF_W +: fe_cfg_pkg::BTB_IDX_W];
  assign w_lk_tag = i_lookup_pc[fe_cfg_pkg::XLEN-1 -: fe_cfg_pkg::BTB_TAG_W];
  assign w_up_idx = i_br_pc[fe_cfg_pkg::OFF_W +: fe_cfg_pkg::BTB_IDX_W];
  assign w_up_tag = i_br_pc[fe_cfg_pkg::XLEN-1 -: fe_cfg_pkg::BTB_TAG_W];

  assign w_lk_hit   = r_valid[w_lk_idx] & (r_tag[w_lk_idx] == w_lk_tag);
  // taken branches allocate
  assign w_up_write = i_br_valid & i_br_taken;
  // a wrong taken guess for this very pc drops the entry
  assign w_up_inval = i_br_valid & i_br_mispredict & ~i_br_taken &
                      (r_tag[w_up_idx] == w_up_tag);

  // ==============================
  // entry valid bits
  // ==============================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else if (w_up_write) begin
      r_valid[w_up_idx] <= 1'b1;
    end else if (w_up_inval) begin
      r_valid[w_up_idx] <= 1'b0;
    end
  end

  // tag and target storage
  always_ff @(posedge i_clk) begin
    if (w_up_write) begin
      r_tag[w_up_idx]    <= w_up_tag;
      r_target[w_up_idx] <= i_br_target;
    end
  end

  // ==============================
  // f1 result
  // ==============================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_pred_taken <= 1'b0;
    end else begin
      o_pred_taken <= i_lookup_valid & w_lk_hit;
    end
  end

  always_ff @(posedge i_clk) begin
    o_pred_target <= r_target[w_lk_idx];
  end

endmodule

`default_nettype wire

// File: design/fe_cfg_pkg.sv
/* fetch unit constants; every fetch is one aligned 32-bit word
   credit counter must be wide enough to hold FETCH_CREDITS */
`default_nettype none

package fe_cfg_pkg;

  // address and instruction datapath
  localparam int XLEN = 32;
  localparam int INST_BYTES = 4;
  // byte offset bits inside one fetch word
  localparam int OFF_W = $clog2(INST_BYTES);
  localparam logic [XLEN-1:0] PC_RESET = 32'h0000_1000;

  // instruction buffer slots owned after reset
  localparam int FETCH_CREDITS = 4;
  localparam int CREDIT_W = 3;

  // direct-mapped btb geometry
  localparam int BTB_ENTRIES = 16;
  localparam int BTB_IDX_W = 4;
  localparam int BTB_TAG_W = XLEN - BTB_IDX_W - OFF_W;

  // commit cause and delegation
  localparam int CAUSE_W = 5;
  localparam int DELEG_W = 16;

endpackage

`default_nettype wire

// File: design/fe_top.sv
/* fetch frontend top; instruction memory answers exactly one cycle after a request
   instruction buffer returns one credit pulse per freed slot */
`timescale 1ns/1ps
`default_nettype none

module fe_top (
  input  logic                               i_clk,
  input  logic                               i_reset_n,
  // commit flush
  input  logic                               i_commit_valid,
  input  logic                               i_commit_is_int,
  input  fe_types_pkg::cause_u               i_commit_cause,
  input  logic [fe_cfg_pkg::XLEN-1:0]        i_commit_epc,
  // csr state
  input  logic [fe_cfg_pkg::XLEN-1:0]        i_mtvec,
  input  logic [fe_cfg_pkg::XLEN-1:0]        i_stvec,
  input  logic [fe_cfg_pkg::XLEN-1:0]        i_mepc,
  input  logic [fe_cfg_pkg::XLEN-1:0]        i_sepc,
  input  logic [fe_cfg_pkg::DELEG_W-1:0]     i_medeleg,
  // branch resolution
  input  logic                               i_br_valid,
  input  logic                               i_br_mispredict,
  input  logic                               i_br_taken,
  input  logic [fe_cfg_pkg::XLEN-1:0]        i_br_pc,
  input  logic [fe_cfg_pkg::XLEN-1:0]        i_br_target,
  // instruction memory
  output logic                               o_imem_req_valid,
  output logic [fe_cfg_pkg::XLEN-1:0]        o_imem_req_addr,
  input  logic [fe_cfg_pkg::XLEN-1:0]        i_imem_rdata,
  // instruction buffer
  output logic                               o_ibuf_valid,
  output logic [fe_cfg_pkg::XLEN-1:0]        o_ibuf_pc,
  output logic [fe_cfg_pkg::XLEN-1:0]        o_ibuf_inst,
  input  logic                               i_ibuf_credit
);

  // ==============================
  // internal nets
  // ==============================
  logic                        w_trap_valid;
  logic [fe_cfg_pkg::XLEN-1:0] w_trap_pc;
  logic                        w_kill;
  logic                        w_f1_valid;
  logic                        w_f2_valid;
  logic                        w_pred_taken;
  logic [fe_cfg_pkg::XLEN-1:0] w_pred_target;

  // commit flush to redirect address
  trap_vector_sel u_trap_vector_sel (
    .i_commit_valid  (i_commit_valid),
    .i_commit_is_int (i_commit_is_int),
    .i_commit_cause  (i_commit_cause),
    .i_commit_epc    (i_commit_epc),
    .i_mtvec         (i_mtvec),
    .i_stvec         (i_stvec),
    .i_mepc          (i_mepc),
    .i_sepc          (i_sepc),
    .i_medeleg       (i_medeleg),
    .o_trap_valid    (w_trap_valid),
    .o_trap_pc       (w_trap_pc)
  );

  // f0 pc, request issue, credits
  fetch_pc_ctrl u_fetch_pc_ctrl (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_trap_valid    (w_trap_valid),
    .i_trap_pc       (w_trap_pc),
    .i_br_valid      (i_br_valid),
    .i_br_mispredict (i_br_mispredict),
    .i_br_taken      (i_br_taken),
    .i_br_pc         (i_br_pc),
    .i_br_target     (i_br_target),
    .i_pred_taken    (w_pred_taken),
    .i_pred_target   (w_pred_target),
    .i_f1_valid      (w_f1_valid),
    .i_f2_valid      (w_f2_valid),
    .i_ibuf_credit   (i_ibuf_credit),
    .o_req_valid     (o_imem_req_valid),
    .o_req_pc        (o_imem_req_addr),
    .o_kill          (w_kill)
  );

  // f1 and f2 stages
  fetch_pipe u_fetch_pipe (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_req_valid  (o_imem_req_valid),
    .i_req_pc     (o_imem_req_addr),
    .i_kill       (w_kill),
    .i_imem_rdata (i_imem_rdata),
    .o_f1_valid   (w_f1_valid),
    .o_f2_valid   (w_f2_valid),
    .o_ibuf_valid (o_ibuf_valid),
    .o_ibuf_pc    (o_ibuf_pc),
    .o_ibuf_inst  (o_ibuf_inst)
  );

  // looked up with the f0 request, answers in f1
  btb u_btb (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_lookup_valid  (o_imem_req_valid),
    .i_lookup_pc     (o_imem_req_addr),
    .i_br_valid      (i_br_valid),
    .i_br_mispredict (i_br_mispredict),
    .i_br_taken      (i_br_taken),
    .i_br_pc         (i_br_pc),
    .i_br_target     (i_br_target),
    .o_pred_taken    (w_pred_taken),
    .o_pred_target   (w_pred_target)
  );

endmodule

`default_nettype wire

// File: design/fe_types_pkg.sv
/* codes 16 to 19 are internal flush and return kinds, not RISC-V causes
   the commit interrupt flag decides which union member is meaningful */
`default_nettype none

package fe_types_pkg;

  // ==============================
  // synchronous exception codes
  // ==============================
  typedef enum logic [fe_cfg_pkg::CAUSE_W-1:0] {
    inst_addr_misalign  = 5'd0,
    inst_acc_fault      = 5'd1,
    illegal_inst        = 5'd2,
    breakpoint          = 5'd3,
    load_addr_misalign  = 5'd4,
    load_acc_fault      = 5'd5,
    stamo_addr_misalign = 5'd6,
    stamo_acc_fault     = 5'd7,
    ecall_u             = 5'd8,
    ecall_s             = 5'd9,
    ecall_m             = 5'd11,
    inst_page_fault     = 5'd12,
    load_page_fault     = 5'd13,
    stamo_page_fault    = 5'd15,
    // pseudo codes for pipeline flushes and xret
    silent_flush        = 5'd16,
    another_flush       = 5'd17,
    mret                = 5'd18,
    sret                = 5'd19
  } exc_code_e;

  // ==============================
  // interrupt codes
  // ==============================
  typedef enum logic [fe_cfg_pkg::CAUSE_W-1:0] {
    s_soft  = 5'd1,
    m_soft  = 5'd3,
    s_timer = 5'd5,
    m_timer = 5'd7,
    s_ext   = 5'd9,
    m_ext   = 5'd11
  } irq_code_e;

  // one cause word, two readings
  typedef union packed {
    exc_code_e exc;
    irq_code_e irq;
  } cause_u;

endpackage

`default_nettype wire

// File: design/fetch_pc_ctrl.sv
/* redirect priority is commit, then branch mispredict, then btb, then sequential
   a request issues only when every in-flight item already holds a credit */
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_ctrl (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  input  logic                        i_trap_valid,
  input  logic [fe_cfg_pkg::XLEN-1:0] i_trap_pc,
  input  logic                        i_br_valid,
  input  logic                        i_br_mispredict,
  input  logic                        i_br_taken,
  input  logic [fe_cfg_pkg::XLEN-1:0] i_br_pc,
  input  logic [fe_cfg_pkg::XLEN-1:0] i_br_target,
  input  logic                        i_pred_taken,
  input  logic [fe_cfg_pkg::XLEN-1:0] i_pred_target,
  input  logic                        i_f1_valid,
  input  logic                        i_f2_valid,
  input  logic                        i_ibuf_credit,
  output logic                        o_req_valid,
  output logic [fe_cfg_pkg::XLEN-1:0] o_req_pc,
  output logic                        o_kill
);

  logic [fe_cfg_pkg::XLEN-1:0]     r_pc;
  logic [fe_cfg_pkg::XLEN-1:0]     w_pc_next;
  logic [fe_cfg_pkg::XLEN-1:0]     w_br_redirect_pc;
  logic [fe_cfg_pkg::CREDIT_W-1:0] r_credits;
  logic [fe_cfg_pkg::CREDIT_W-1:0] w_inflight;
  logic                            r_run;
  logic                            w_br_redirect;
  logic                            w_can_issue;
  logic                            w_deliver;

  // ==============================
  // redirect and kill
  // ==============================
  assign w_br_redirect = i_br_valid & i_br_mispredict;
  // any redirect flushes both younger stages
  assign o_kill = i_trap_valid | w_br_redirect;

  // not-taken mispredict resumes after the branch
  assign w_br_redirect_pc = i_br_taken ? i_br_target :
                            i_br_pc + (fe_cfg_pkg::XLEN)'(fe_cfg_pkg::INST_BYTES);

  // ==============================
  // request issue
  // ==============================
  // items in f1/f2 still owe a slot
  assign w_inflight = (fe_cfg_pkg::CREDIT_W)'(i_f1_valid) +
                      (fe_cfg_pkg::CREDIT_W)'(i_f2_valid);
  assign w_can_issue = r_credits > w_inflight;

  // hold the request while redirecting or turning to a predicted target
  assign o_req_valid = r_run & w_can_issue & ~o_kill & ~i_pred_taken;
  assign o_req_pc = r_pc;

  // f2 item leaves this cycle unless flushed
  assign w_deliver = i_f2_valid & ~o_kill;

  // next f0 pc
  always_comb begin
    if (i_trap_valid) begin
      w_pc_next = i_trap_pc;
    end else if (w_br_redirect) begin
      w_pc_next = w_br_redirect_pc;
    end else if (i_pred_taken) begin
      w_pc_next = i_pred_target;
    end else if (o_req_valid) begin
      w_pc_next = r_pc + (fe_cfg_pkg::XLEN)'(fe_cfg_pkg::INST_BYTES);
    end else begin
      // pc holds while out of credit
      w_pc_next = r_pc;
    end
  end

  // ==============================
  // state
  // ==============================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_run     <= 1'b0;
      r_pc      <= fe_cfg_pkg::PC_RESET;
      r_credits <= (fe_cfg_pkg::CREDIT_W)'(fe_cfg_pkg::FETCH_CREDITS);
    end else begin
      // first request one cycle after release
      r_run     <= 1'b1;
      r_pc      <= w_pc_next;
      // spend on delivery, refill on buffer pulse
      r_credits <= r_credits - (fe_cfg_pkg::CREDIT_W)'(w_deliver) +
                   (fe_cfg_pkg::CREDIT_W)'(i_ibuf_credit);
    end
  end

endmodule

`default_nettype wire

// File: design/fetch_pipe.sv
/* at most two items in flight; memory data must arrive while the item sits in f1
   a killed f2 item is never presented to the instruction buffer */
`timescale 1ns/1ps
`default_nettype none

module fetch_pipe (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  input  logic                        i_req_valid,
  input  logic [fe_cfg_pkg::XLEN-1:0] i_req_pc,
  input  logic                        i_kill,
  input  logic [fe_cfg_pkg::XLEN-1:0] i_imem_rdata,
  output logic                        o_f1_valid,
  output logic                        o_f2_valid,
  output logic                        o_ibuf_valid,
  output logic [fe_cfg_pkg::XLEN-1:0] o_ibuf_pc,
  output logic [fe_cfg_pkg::XLEN-1:0] o_ibuf_inst
);

  logic                        r_f1_valid;
  logic [fe_cfg_pkg::XLEN-1:0] r_f1_pc;
  logic                        r_f2_valid;
  logic [fe_cfg_pkg::XLEN-1:0] r_f2_pc;
  logic [fe_cfg_pkg::XLEN-1:0] r_f2_inst;

  // ==============================
  // stage valids
  // ==============================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_f1_valid <= 1'b0;
      r_f2_valid <= 1'b0;
    end else begin
      // kill drops both stages at the edge
      r_f1_valid <= i_req_valid & ~i_kill;
      r_f2_valid <= r_f1_valid & ~i_kill;
    end
  end

  // ==============================
  // stage payload
  // ==============================
  always_ff @(posedge i_clk) begin
    if (i_req_valid) begin
      r_f1_pc <= i_req_pc;
    end
    // read data lines up with the f1 item
    if (r_f1_valid) begin
      r_f2_pc   <= r_f1_pc;
      r_f2_inst <= i_imem_rdata;
    end
  end

  assign o_f1_valid = r_f1_valid;
  assign o_f2_valid = r_f2_valid;

  // instruction buffer side
  assign o_ibuf_valid = r_f2_valid & ~i_kill;
  assign o_ibuf_pc    = r_f2_pc;
  assign o_ibuf_inst  = r_f2_inst;

endmodule

`default_nettype wire

// File: design/trap_vector_sel.sv
/* purely combinational; interrupts use direct-mode mtvec plus four times the cause
   exception codes above 15 never delegate */
`timescale 1ns/1ps
`default_nettype none

module trap_vector_sel (
  input  logic                           i_commit_valid,
  input  logic                           i_commit_is_int,
  input  fe_types_pkg::cause_u           i_commit_cause,
  input  logic [fe_cfg_pkg::XLEN-1:0]    i_commit_epc,
  input  logic [fe_cfg_pkg::XLEN-1:0]    i_mtvec,
  input  logic [fe_cfg_pkg::XLEN-1:0]    i_stvec,
  input  logic [fe_cfg_pkg::XLEN-1:0]    i_mepc,
  input  logic [fe_cfg_pkg::XLEN-1:0]    i_sepc,
  input  logic [fe_cfg_pkg::DELEG_W-1:0] i_medeleg,
  output logic                           o_trap_valid,
  output logic [fe_cfg_pkg::XLEN-1:0]    o_trap_pc
);

  logic [fe_cfg_pkg::CAUSE_W-1:0] w_exc_raw;
  logic [fe_cfg_pkg::XLEN-1:0]    w_int_base;
  logic [fe_cfg_pkg::XLEN-1:0]    w_int_off;
  logic                           w_delegated;

  assign o_trap_valid = i_commit_valid;

  // ==============================
  // interrupt reading
  // ==============================
  // mode bit dropped from the vector base
  assign w_int_base = {i_mtvec[fe_cfg_pkg::XLEN-1:1], 1'b0};
  assign w_int_off  = (fe_cfg_pkg::XLEN)'({i_commit_cause.irq, 2'b00});

  // ==============================
  // exception reading
  // ==============================
  assign w_exc_raw = i_commit_cause.exc;
  // only real exception codes 0..15 look at their medeleg bit
  assign w_delegated = ~w_exc_raw[fe_cfg_pkg::CAUSE_W-1] &
                       i_medeleg[w_exc_raw[fe_cfg_pkg::CAUSE_W-2:0]];

  always_comb begin
    o_trap_pc = i_mtvec;
    if (i_commit_is_int) begin
      o_trap_pc = w_int_base + w_int_off;
    end else begin
      case (i_commit_cause.exc)
        // refetch after the flushing instruction
        fe_types_pkg::silent_flush: begin
          o_trap_pc = i_commit_epc + (fe_cfg_pkg::XLEN)'(fe_cfg_pkg::INST_BYTES);
        end
        // refetch the flushing instruction itself
        fe_types_pkg::another_flush: begin
          o_trap_pc = i_commit_epc;
        end
        fe_types_pkg::mret: begin
          o_trap_pc = i_mepc;
        end
        fe_types_pkg::sret: begin
          o_trap_pc = i_sepc;
        end
        default: begin
          // delegated traps go to supervisor handler
          o_trap_pc = w_delegated ? i_stvec : i_mtvec;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: test/fe_top_sva.sv
/* checks top-level ports only; delivery count is tracked against returned credits */
`timescale 1ns/1ps
`default_nettype none

module fe_top_sva (
  input logic                        i_clk,
  input logic                        i_reset_n,
  input logic                        i_req_valid,
  input logic [fe_cfg_pkg::XLEN-1:0] i_req_addr,
  input logic                        i_ibuf_valid,
  input logic                        i_ibuf_credit
);

  // items held by the instruction buffer
  int r_held;
  // number of property failures so far
  int fail_cnt;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_held <= 0;
    end else begin
      r_held <= r_held + (i_ibuf_valid ? 1 : 0) - (i_ibuf_credit ? 1 : 0);
    end
  end

  // ==============================
  // properties
  // ==============================
  req_aligned_a : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_req_valid |-> (i_req_addr[fe_cfg_pkg::OFF_W-1:0] == '0))
    else begin
      fail_cnt++;
      $error("request address not word aligned");
    end

  // no delivery while reset is low
  no_ibuf_in_reset_a : assert property (@(posedge i_clk)
    !i_reset_n |-> !i_ibuf_valid)
    else begin
      fail_cnt++;
      $error("instruction delivered during reset");
    end

  held_le_credits_a : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    r_held <= fe_cfg_pkg::FETCH_CREDITS)
    else begin
      fail_cnt++;
      $error("deliveries exceed instruction buffer credits");
    end

endmodule

bind fe_top fe_top_sva sva_i (
  .i_clk         (i_clk),
  .i_reset_n     (i_reset_n),
  .i_req_valid   (o_imem_req_valid),
  .i_req_addr    (o_imem_req_addr),
  .i_ibuf_valid  (o_ibuf_valid),
  .i_ibuf_credit (i_ibuf_credit)
);

`default_nettype wire

// File: test/tb_clk_gen.sv
/* free-running 8 ns clock; reset released 1 ns after the 16th rising edge */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #4 o_clk = ~o_clk;
  end

  // active-low reset held for 16 cycles
  initial begin
    o_reset_n = 1'b0;
    repeat (16) @(posedge o_clk);
    #1 o_reset_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: test/tb_fe_top.sv
/* memory answers addr xor a fixed key one cycle after every request
   credits come back at random while the buffer model holds items */
`timescale 1ns/1ps
`default_nettype none

module tb_fe_top;

  localparam logic [fe_cfg_pkg::XLEN-1:0] INST_KEY = 32'hA5A5_5A5A;
  localparam logic [fe_cfg_pkg::XLEN-1:0] MTVEC = 32'h0000_8000;
  localparam logic [fe_cfg_pkg::XLEN-1:0] STVEC = 32'h0000_9000;
  localparam logic [fe_cfg_pkg::XLEN-1:0] MEPC = 32'h0000_A000;
  localparam logic [fe_cfg_pkg::XLEN-1:0] SEPC = 32'h0000_B000;
  localparam int NROWS = 10;
  localparam int TIMEOUT = 200;

  logic clk;
  logic reset_n;
  logic i_commit_valid;
  logic i_commit_is_int;
  fe_types_pkg::cause_u i_commit_cause;
  logic [fe_cfg_pkg::XLEN-1:0] i_commit_epc;
  logic [fe_cfg_pkg::DELEG_W-1:0] i_medeleg;
  logic i_br_valid;
  logic i_br_mispredict;
  logic i_br_taken;
  logic [fe_cfg_pkg::XLEN-1:0] i_br_pc;
  logic [fe_cfg_pkg::XLEN-1:0] i_br_target;
  logic o_imem_req_valid;
  logic [fe_cfg_pkg::XLEN-1:0] o_imem_req_addr;
  logic [fe_cfg_pkg::XLEN-1:0] i_imem_rdata;
  logic o_ibuf_valid;
  logic [fe_cfg_pkg::XLEN-1:0] o_ibuf_pc;
  logic [fe_cfg_pkg::XLEN-1:0] o_ibuf_inst;
  logic i_ibuf_credit;

  // buffer model and monitor state
  logic [fe_cfg_pkg::XLEN-1:0] deliv_q[$];
  logic [fe_cfg_pkg::XLEN-1:0] inst_q[$];
  int occ;
  int idle_cnt;
  bit credit_en;
  int seed;

  // redirect table kind is 0 for commit and 1 for branch mispredict
  bit row_kind [NROWS];
  bit row_is_int [NROWS];
  logic [fe_cfg_pkg::CAUSE_W-1:0] row_cause [NROWS];
  logic [fe_cfg_pkg::XLEN-1:0] row_epc [NROWS];
  bit row_taken [NROWS];
  logic [fe_cfg_pkg::XLEN-1:0] row_br_pc [NROWS];
  logic [fe_cfg_pkg::XLEN-1:0] row_exp [NROWS];

  tb_clk_gen clk_gen_i (.o_clk(clk), .o_reset_n(reset_n));

  fe_top dut_i (
    .i_clk(clk), .i_reset_n(reset_n),
    .i_commit_valid(i_commit_valid), .i_commit_is_int(i_commit_is_int),
    .i_commit_cause(i_commit_cause), .i_commit_epc(i_commit_epc),
    .i_mtvec(MTVEC), .i_stvec(STVEC), .i_mepc(MEPC), .i_sepc(SEPC),
    .i_medeleg(i_medeleg),
    .i_br_valid(i_br_valid), .i_br_mispredict(i_br_mispredict),
    .i_br_taken(i_br_taken), .i_br_pc(i_br_pc), .i_br_target(i_br_target),
    .o_imem_req_valid(o_imem_req_valid), .o_imem_req_addr(o_imem_req_addr),
    .i_imem_rdata(i_imem_rdata),
    .o_ibuf_valid(o_ibuf_valid), .o_ibuf_pc(o_ibuf_pc), .o_ibuf_inst(o_ibuf_inst),
    .i_ibuf_credit(i_ibuf_credit)
  );

  // ==============================
  // compare tasks
  // ==============================
  task automatic check_addr(input string name, input logic [fe_cfg_pkg::XLEN-1:0] got,
                            input logic [fe_cfg_pkg::XLEN-1:0] exp);
    if (got !== exp) begin
      $display("error: %s got 0x%h expected 0x%h", name, got, exp);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic check_inst(input string name, input logic [fe_cfg_pkg::XLEN-1:0] got,
                            input logic [fe_cfg_pkg::XLEN-1:0] exp);
    if (got !== exp) begin
      $display("error: %s got 0x%h expected 0x%h", name, got, exp);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("error: %s got 0x%h expected 0x%h", name, got, exp);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("sim failed");
    $fatal(1);
  endtask

  // ==============================
  // memory, buffer and monitor
  // ==============================
  // request address sampled mid-cycle, data driven after the next edge
  always @(negedge clk) begin : imem_model
    logic [fe_cfg_pkg::XLEN-1:0] req_addr;
    req_addr = o_imem_req_addr;
    @(posedge clk);
    #1;
    i_imem_rdata = req_addr ^ INST_KEY;
  end

  always @(negedge clk) begin
    if (reset_n) begin
      if (o_ibuf_valid) begin
        deliv_q.push_back(o_ibuf_pc);
        inst_q.push_back(o_ibuf_inst);
        occ++;
      end
      idle_cnt = (o_imem_req_valid || o_ibuf_valid) ? 0 : idle_cnt + 1;
    end
  end

  // random slot release
  always @(posedge clk) begin : credit_return
    int r;
    #1;
    r = $random(seed);
    if (credit_en && occ > 0 && r[0]) begin
      i_ibuf_credit = 1'b1;
      occ--;
    end else begin
      i_ibuf_credit = 1'b0;
    end
  end

  // ==============================
  // waits and drivers
  // ==============================
  task automatic wait_req(output logic [fe_cfg_pkg::XLEN-1:0] addr);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) report_timeout("an instruction request");
    end while (!o_imem_req_valid);
    addr = o_imem_req_addr;
  endtask

  // next delivered item must carry this pc and its memory word
  task automatic expect_delivery(input logic [fe_cfg_pkg::XLEN-1:0] exp);
    logic [fe_cfg_pkg::XLEN-1:0] pc;
    logic [fe_cfg_pkg::XLEN-1:0] inst;
    int n;
    n = 0;
    while (deliv_q.size() == 0) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) report_timeout("an instruction delivery");
    end
    pc = deliv_q.pop_front();
    inst = inst_q.pop_front();
    check_addr("o_ibuf_pc", pc, exp);
    check_inst("o_ibuf_inst", inst, exp ^ INST_KEY);
  endtask

  task automatic apply_redirect(input int row);
    @(posedge clk);
    #1;
    if (row_kind[row]) begin
      i_br_valid = 1'b1;
      i_br_mispredict = 1'b1;
      i_br_taken = row_taken[row];
      i_br_pc = row_br_pc[row];
      i_br_target = row_exp[row];
    end else begin
      i_commit_valid = 1'b1;
      i_commit_is_int = row_is_int[row];
      i_commit_cause = row_cause[row];
      i_commit_epc = row_epc[row];
    end
    // older deliveries are from before the redirect
    deliv_q.delete();
    inst_q.delete();
    @(posedge clk);
    #1;
    i_commit_valid = 1'b0;
    i_br_valid = 1'b0;
    i_br_mispredict = 1'b0;
  endtask

  task automatic train_btb(input logic [fe_cfg_pkg::XLEN-1:0] pc,
                           input logic [fe_cfg_pkg::XLEN-1:0] tgt);
    @(posedge clk);
    #1;
    i_br_valid = 1'b1;
    i_br_taken = 1'b1;
    i_br_pc = pc;
    i_br_target = tgt;
    @(posedge clk);
    #1;
    i_br_valid = 1'b0;
    i_br_taken = 1'b0;
  endtask

  task automatic set_row(input int i, input bit kind, input bit is_int,
                         input logic [fe_cfg_pkg::CAUSE_W-1:0] cause,
                         input logic [fe_cfg_pkg::XLEN-1:0] epc, input bit taken,
                         input logic [fe_cfg_pkg::XLEN-1:0] br_pc,
                         input logic [fe_cfg_pkg::XLEN-1:0] exp);
    row_kind[i] = kind;
    row_is_int[i] = is_int;
    row_cause[i] = cause;
    row_epc[i] = epc;
    row_taken[i] = taken;
    row_br_pc[i] = br_pc;
    row_exp[i] = exp;
  endtask

  // interrupts land at mtvec plus four times the cause
  // ecall_u is delegated to stvec
  task automatic load_table;
    set_row(0, 0, 1, fe_types_pkg::m_timer, '0, 0, '0, MTVEC + 32'd28);
    set_row(1, 0, 1, fe_types_pkg::s_ext, '0, 0, '0, MTVEC + 32'd36);
    set_row(2, 0, 0, fe_types_pkg::ecall_u, 32'h2200, 0, '0, STVEC);
    set_row(3, 0, 0, fe_types_pkg::illegal_inst, 32'h2300, 0, '0, MTVEC);
    set_row(4, 0, 0, fe_types_pkg::mret, '0, 0, '0, MEPC);
    set_row(5, 0, 0, fe_types_pkg::sret, '0, 0, '0, SEPC);
    set_row(6, 0, 0, fe_types_pkg::silent_flush, 32'h2000, 0, '0, 32'h2004);
    set_row(7, 0, 0, fe_types_pkg::another_flush, 32'h2100, 0, '0, 32'h2100);
    // taken mispredict goes to target, not taken to pc + 4
    set_row(8, 1, 0, '0, '0, 1, 32'h1100, 32'h4000);
    set_row(9, 1, 0, '0, '0, 0, 32'h4100, 32'h4104);
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial begin : main
    logic [fe_cfg_pkg::XLEN-1:0] a;
    logic [fe_cfg_pkg::XLEN-1:0] exp_pc;
    int n;
    i_commit_valid = 1'b0;
    i_commit_is_int = 1'b0;
    i_commit_cause = '0;
    i_commit_epc = '0;
    i_medeleg = 16'h0100;
    i_br_valid = 1'b0;
    i_br_mispredict = 1'b0;
    i_br_taken = 1'b0;
    i_br_pc = '0;
    i_br_target = '0;
    i_imem_rdata = '0;
    i_ibuf_credit = 1'b0;
    occ = 0;
    idle_cnt = 0;
    credit_en = 1'b1;
    seed = 32'h50fc_0fcc;
    load_table();

    n = 0;
    while (!reset_n) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) report_timeout("reset release");
    end

    // sequential fetch from the reset vector
    for (int i = 0; i < 3; i++) begin
      wait_req(a);
      check_addr("o_imem_req_addr", a, fe_cfg_pkg::PC_RESET + 32'(4 * i));
    end
    for (int i = 0; i < 3; i++) begin
      expect_delivery(fe_cfg_pkg::PC_RESET + 32'(4 * i));
    end

    // commit and branch redirects; first delivery must be the target
    for (int r = 0; r < NROWS; r++) begin
      apply_redirect(r);
      wait_req(a);
      check_addr("o_imem_req_addr", a, row_exp[r]);
      expect_delivery(row_exp[r]);
    end

    // btb predicted taken branch
    train_btb(32'h3000, 32'h3400);
    set_row(0, 0, 0, fe_types_pkg::another_flush, 32'h3000, 0, '0, 32'h3000);
    apply_redirect(0);
    wait_req(a);
    check_addr("o_imem_req_addr", a, 32'h3000);
    wait_req(a);
    check_addr("o_imem_req_addr", a, 32'h3400);
    expect_delivery(32'h3000);
    expect_delivery(32'h3400);

    // back-pressure with no slot release
    @(posedge clk);
    credit_en = 1'b0;
    n = 0;
    while (idle_cnt < 8) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) report_timeout("fetch to stall");
    end
    check_count("ibuf occupancy", occ, fe_cfg_pkg::FETCH_CREDITS);
    // fetch runs on sequentially from the predicted target
    exp_pc = 32'h3404;
    while (deliv_q.size() > 0) begin
      expect_delivery(exp_pc);
      exp_pc = exp_pc + 32'd4;
    end
    credit_en = 1'b1;
    for (int i = 0; i < 6; i++) begin
      expect_delivery(exp_pc);
      exp_pc = exp_pc + 32'd4;
    end

    if (dut_i.sva_i.fail_cnt == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("bound assertions reported failures");
      $display("sim failed");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire
